// ==== src/spiPkg.sv ====
// SPI frame layout. Assumes a 32-bit address then a 32-bit data word, both MSB first, no framing bits
package spiPkg;

	// ------------------------------
	// Word types
	// ------------------------------

	// One word on the SPI wire
	// Same width for address and data
	typedef logic [31:0] spiWord_t;

	// ------------------------------
	// Frame types
	// ------------------------------

	// Full frame as it sits in the FIFO
	// Address in the upper half since it arrives first
	typedef struct packed
	{
		spiWord_t addr;
		spiWord_t data;
	} spiFrame_t;

	// SCK rising edges per complete frame
	localparam int FRAME_BITS = $bits(spiFrame_t);

endpackage

// ==== src/busPkg.sv ====
// Wishbone classic types, write-only master side, no byte selects, REG_COUNT must be a power of two
package busPkg;

	// ------------------------------
	// Bus widths
	// ------------------------------

	// Word address, not byte address
	typedef logic [31:0] wbAdr_t;

	// Data word
	typedef logic [31:0] wbDat_t;

	// ------------------------------
	// Request and response
	// ------------------------------

	// Master to slave
	typedef struct packed
	{
		logic   cyc;
		logic   stb;
		logic   we;
		wbAdr_t adr;
		wbDat_t datW;
	} wbReq_t;

	// Slave to master
	typedef struct packed
	{
		logic   ack;
		wbDat_t datR;
	} wbRsp_t;

	// Register index from a bus address
	// Higher bits alias, count is a power of two
	function automatic wbAdr_t regIndex(input wbAdr_t adr, input int unsigned count);
		return adr & wbAdr_t'(count - 1);
	endfunction

	// Full-word write request, cycle and strobe raised
	function automatic wbReq_t wbWrite(input wbAdr_t adr, input wbDat_t dat);
		wbReq_t req;
		req.cyc  = 1'b1;
		req.stb  = 1'b1;
		req.we   = 1'b1;
		req.adr  = adr;
		req.datW = dat;
		return req;
	endfunction

endpackage

// ==== src/spiSlaveFrontend.sv ====
// SPI mode 0 slave only. SCK half period must be at least 4 system clocks, partial frames are dropped
`timescale 1ns/1ns

module spiSlaveFrontend
(
	input  logic              iSCLK,
	input  logic              iSRST,
	input  logic              iSck,
	input  logic              iCs,
	input  logic              iMosi,
	input  busPkg::wbDat_t    rdData,
	output logic              oMiso,
	output spiPkg::spiWord_t  rdAddr,
	output spiPkg::spiFrame_t frame,
	output logic              push
);
	import spiPkg::*;
	import busPkg::*;

	// Bits per half frame, address then data
	localparam int HALF_BITS = FRAME_BITS / 2;
	localparam int CNT_W     = $clog2(FRAME_BITS);
	localparam int DAT_W     = $bits(wbDat_t);

	// Pin synchronizers, oldest sample in bit 2
	logic [2:0] sckSync;
	logic [2:0] csSync;
	logic [2:0] mosiSync;

	// Edge strobes
	logic sckRise;
	logic sckFall;

	// Frame position
	logic [CNT_W-1:0] bitCnt;
	logic dataHalf;

	// Payload
	logic [FRAME_BITS-1:0] frameShift;
	logic loadRb;
	wbDat_t misoShift;

	// ------------------------------
	// Pin synchronization
	// ------------------------------

	always_ff @(posedge iSCLK)
	begin
		if (iSRST)
		begin
			sckSync  <= 3'b000;
			// CS idles deselected
			csSync   <= 3'b111;
			mosiSync <= 3'b000;
		end
		else
		begin
			sckSync  <= {sckSync[1:0], iSck};
			csSync   <= {csSync[1:0], iCs};
			mosiSync <= {mosiSync[1:0], iMosi};
		end
	end

	// Edges only count while selected
	// Old sample in bit 2, new one in bit 1
	assign sckRise = !csSync[2] && (sckSync[2:1] == 2'b01);
	assign sckFall = !csSync[2] && (sckSync[2:1] == 2'b10);

	// Upper half of the count is the data word
	assign dataHalf = (bitCnt >= CNT_W'(HALF_BITS));

	// ------------------------------
	// Bit counter and capture
	// ------------------------------

	always_ff @(posedge iSCLK)
	begin
		if (iSRST || csSync[2])
			bitCnt <= '0;
		else if (sckRise)
			// Wraps to zero after the last bit
			bitCnt <= bitCnt + 1'b1;
	end

	// Shift MOSI in on every rising edge
	always_ff @(posedge iSCLK)
	begin
		if (sckRise)
			frameShift <= {frameShift[FRAME_BITS-2:0], mosiSync[2]};
	end

	always_ff @(posedge iSCLK)
	begin
		if (iSRST)
		begin
			rdAddr <= '0;
			loadRb <= 1'b0;
			push   <= 1'b0;
		end
		else
		begin
			// Address complete at rising edge 32
			if (sckRise && (bitCnt == CNT_W'(HALF_BITS - 1)))
				rdAddr <= {frameShift[HALF_BITS-2:0], mosiSync[2]};
			// Register bank answers combinationally, so load one clock later
			loadRb <= sckRise && (bitCnt == CNT_W'(HALF_BITS - 1));
			// Whole frame in after rising edge 64
			push   <= sckRise && (bitCnt == CNT_W'(FRAME_BITS - 1));
		end
	end

	assign frame = spiFrame_t'(frameShift);

	// ------------------------------
	// MISO readback
	// ------------------------------

	// Old register value, shifted out MSB first
	// Ones fill in behind the last bit
	always_ff @(posedge iSCLK)
	begin
		if (loadRb)
			misoShift <= rdData;
		else if (sckFall && dataHalf)
			misoShift <= {misoShift[DAT_W-2:0], 1'b1};
	end

	always_ff @(posedge iSCLK)
	begin
		if (iSRST)
			oMiso <= 1'b1;
		else if (csSync[2] || !dataHalf)
			// Idle high in the address half
			oMiso <= 1'b1;
		else if (sckFall)
			// Falling edge 32 presents bit 31
			oMiso <= misoShift[DAT_W-1];
	end

	// Frame handoff only inside an active selection
	assert property (@(posedge iSCLK) disable iff (iSRST) push |-> !csSync[2]);

endmodule

// ==== src/frameFifo.sv ====
// Frame FIFO, single clock. A push while full is lost and latches overflow until reset
`timescale 1ns/1ns

module frameFifo
#(
	parameter int FIFO_DEPTH = 4
)
(
	input  logic              iSCLK,
	input  logic              iSRST,
	input  spiPkg::spiFrame_t frame,
	input  logic              push,
	input  logic              pop,
	output spiPkg::spiFrame_t head,
	output logic              empty,
	output logic              oOverflow
);
	import spiPkg::*;

	localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
	localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

	// Storage
	spiFrame_t mem [FIFO_DEPTH];

	// Pointers and occupancy
	logic [PTR_W-1:0] wrPtr;
	logic [PTR_W-1:0] rdPtr;
	logic [CNT_W-1:0] count;
	logic full;
	logic doPush;
	logic doPop;

	// Circular increment, depth need not be a power of two
	function automatic logic [PTR_W-1:0] nextPtr(input logic [PTR_W-1:0] ptr);
		if (ptr == PTR_W'(FIFO_DEPTH - 1))
			return '0;
		return ptr + 1'b1;
	endfunction

	assign full   = (count == CNT_W'(FIFO_DEPTH));
	assign empty  = (count == '0);
	assign doPush = push && !full;
	assign doPop  = pop && !empty;

	// First-word fall-through
	assign head = mem[rdPtr];

	always_ff @(posedge iSCLK)
	begin
		if (doPush)
			mem[wrPtr] <= frame;
	end

	// ------------------------------
	// Control
	// ------------------------------

	always_ff @(posedge iSCLK)
	begin
		if (iSRST)
		begin
			wrPtr     <= '0;
			rdPtr     <= '0;
			count     <= '0;
			oOverflow <= 1'b0;
		end
		else
		begin
			if (doPush)
				wrPtr <= nextPtr(wrPtr);
			if (doPop)
				rdPtr <= nextPtr(rdPtr);
			case ({doPush, doPop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
			// Sticky, dropped frame
			if (push && full)
				oOverflow <= 1'b1;
		end
	end

	// Consumer only pops what it was shown
	assert property (@(posedge iSCLK) disable iff (iSRST) pop |-> !empty);
	assert property (@(posedge iSCLK) disable iff (iSRST) count <= CNT_W'(FIFO_DEPTH));

endmodule

// ==== src/wbRegMaster.sv ====
// Wishbone classic write master, one write per frame. A granted cycle runs to ack even if grant drops
`timescale 1ns/1ns

module wbRegMaster
(
	input  logic              iSCLK,
	input  logic              iSRST,
	input  spiPkg::spiFrame_t head,
	input  logic              empty,
	input  logic              iBusGrant,
	input  busPkg::wbRsp_t    wbRsp,
	output logic              pop,
	output busPkg::wbReq_t    wbReq
);
	import busPkg::*;

	// Bus FSM
	typedef enum logic [1:0]
	{
		IDLE,
		BUS,
		DONE
	} state_t;

	state_t state;

	// ------------------------------
	// FSM and request register
	// ------------------------------

	always_ff @(posedge iSCLK)
	begin
		if (iSRST)
		begin
			state <= IDLE;
			wbReq <= '0;
		end
		else
		begin
			case (state)
				IDLE:
				begin
					// Start only with a frame waiting and the bus granted
					if (!empty && iBusGrant)
					begin
						state <= BUS;
						wbReq <= wbWrite(head.addr, head.data);
					end
				end
				BUS:
				begin
					// Hold everything until the slave acks
					if (wbRsp.ack)
					begin
						state <= DONE;
						wbReq <= '0;
					end
				end
				DONE:
					// One idle bus cycle between writes
					state <= IDLE;
				default:
					state <= IDLE;
			endcase
		end
	end

	// Frame leaves the FIFO on the ack edge
	assign pop = (state == BUS) && wbRsp.ack;

	// Strobe only inside a cycle
	assert property (@(posedge iSCLK) disable iff (iSRST) wbReq.stb |-> wbReq.cyc);

	// Request frozen while waiting for ack
	assert property (@(posedge iSCLK) disable iff (iSRST)
		(wbReq.stb && !wbRsp.ack) |=> $stable(wbReq));

endmodule

// ==== src/regBank.sv ====
// Wishbone classic register file, full-word writes only. Addresses alias modulo REG_COUNT
`timescale 1ns/1ns

module regBank
#(
	parameter int REG_COUNT = 16
)
(
	input  logic             iSCLK,
	input  logic             iSRST,
	input  busPkg::wbReq_t   wbReq,
	input  spiPkg::spiWord_t rdAddr,
	output busPkg::wbRsp_t   wbRsp,
	output busPkg::wbDat_t   rdData
);
	import busPkg::*;

	localparam int IDX_W = (REG_COUNT > 1) ? $clog2(REG_COUNT) : 1;

	// Register array
	wbDat_t regs [REG_COUNT];

	// Aliased indices
	wbAdr_t wrSel;
	wbAdr_t rdSel;
	logic [IDX_W-1:0] wrIdx;
	logic [IDX_W-1:0] rdIdx;

	// Handshake
	logic ack;
	logic strobe;

	assign wrSel = regIndex(wbReq.adr, REG_COUNT);
	assign rdSel = regIndex(rdAddr, REG_COUNT);
	assign wrIdx = wrSel[IDX_W-1:0];
	assign rdIdx = rdSel[IDX_W-1:0];

	// New strobe, not the one already acked
	assign strobe = wbReq.cyc && wbReq.stb && !ack;

	// ------------------------------
	// Write port
	// ------------------------------

	always_ff @(posedge iSCLK)
	begin
		if (iSRST)
		begin
			ack  <= 1'b0;
			regs <= '{default: '0};
		end
		else
		begin
			ack <= strobe;
			// Write lands on the ack edge
			if (strobe && wbReq.we)
				regs[wrIdx] <= wbReq.datW;
		end
	end

	assign wbRsp.ack  = ack;
	assign wbRsp.datR = regs[wrIdx];

	// SPI readback, combinational
	assign rdData = regs[rdIdx];

	// Single-cycle ack per strobe
	assert property (@(posedge iSCLK) disable iff (iSRST) wbRsp.ack |=> !wbRsp.ack);

endmodule

// ==== src/spiBridgeTop.sv ====
// SPI-to-register bridge. No port marks write completion, readback needs a quiet gap under grant
`timescale 1ns/1ns

module spiBridgeTop
#(
	parameter int FIFO_DEPTH = 4,
	parameter int REG_COUNT  = 16
)
(
	input  logic iSCLK,
	input  logic iSRST,
	input  logic iSck,
	input  logic iCs,
	input  logic iMosi,
	input  logic iBusGrant,
	output logic oMiso,
	output logic oOverflow
);
	import spiPkg::*;
	import busPkg::*;

	// ------------------------------
	// Internal paths
	// ------------------------------

	// Producer to buffer
	spiFrame_t frame;
	logic push;

	// Buffer to consumer
	spiFrame_t head;
	logic empty;
	logic pop;

	// Consumer to register bank
	wbReq_t wbReq;
	wbRsp_t wbRsp;

	// Readback
	spiWord_t rdAddr;
	wbDat_t rdData;

	spiSlaveFrontend u_spiSlaveFrontend
	(
		.iSCLK  (iSCLK),
		.iSRST  (iSRST),
		.iSck   (iSck),
		.iCs    (iCs),
		.iMosi  (iMosi),
		.rdData (rdData),
		.oMiso  (oMiso),
		.rdAddr (rdAddr),
		.frame  (frame),
		.push   (push)
	);

	frameFifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_frameFifo
	(
		.iSCLK     (iSCLK),
		.iSRST     (iSRST),
		.frame     (frame),
		.push      (push),
		.pop       (pop),
		.head      (head),
		.empty     (empty),
		.oOverflow (oOverflow)
	);

	wbRegMaster u_wbRegMaster
	(
		.iSCLK     (iSCLK),
		.iSRST     (iSRST),
		.head      (head),
		.empty     (empty),
		.iBusGrant (iBusGrant),
		.wbRsp     (wbRsp),
		.pop       (pop),
		.wbReq     (wbReq)
	);

	regBank #(.REG_COUNT(REG_COUNT)) u_regBank
	(
		.iSCLK  (iSCLK),
		.iSRST  (iSRST),
		.wbReq  (wbReq),
		.rdAddr (rdAddr),
		.wbRsp  (wbRsp),
		.rdData (rdData)
	);

endmodule

// ==== verification/spiBridgeTb.sv ====
// Bridge testbench. SCK half period fixed at 4 clocks, readback only after a quiet gap under grant
`timescale 1ns/1ns

module spiBridgeTb;
	import spiPkg::*;

	localparam int FIFO_DEPTH = 4;
	localparam int REG_COUNT  = 16;
	localparam int RESET_CLKS = 4;
	localparam int SCK_HALF   = 4;
	localparam int CS_GAP     = 8;
	localparam int GAP_CLKS   = 24;
	localparam int N_RANDOM   = 6;
	localparam int N_FRAMES   = 1 + 2 * N_RANDOM + 2 + 2 * (FIFO_DEPTH + 1) + 3;
	// Each frame plus its gap, doubled for margin
	localparam int TIMEOUT_CLKS =
		2 * (N_FRAMES * (FRAME_BITS * 2 * SCK_HALF + GAP_CLKS + 8 * FIFO_DEPTH) + RESET_CLKS);

	logic iSCLK;
	logic iSRST;
	logic iSck;
	logic iCs;
	logic iMosi;
	logic iBusGrant;
	logic oMiso;
	logic oOverflow;

	// Reference register model
	spiWord_t refRegs [REG_COUNT];
	spiWord_t rngState;
	int cycleCount;

	// Stimulus scratch
	spiWord_t addrA;
	spiWord_t dataA;
	spiWord_t dataB;
	spiWord_t base;
	spiWord_t stallAddr [FIFO_DEPTH + 1];
	spiWord_t stallData [FIFO_DEPTH + 1];
	int k;

	spiBridgeTop #(.FIFO_DEPTH(FIFO_DEPTH), .REG_COUNT(REG_COUNT)) u_spiBridgeTop
	(
		.iSCLK     (iSCLK),
		.iSRST     (iSRST),
		.iSck      (iSck),
		.iCs       (iCs),
		.iMosi     (iMosi),
		.iBusGrant (iBusGrant),
		.oMiso     (oMiso),
		.oOverflow (oOverflow)
	);

	// 100 ns system clock
	initial
	begin
		iSCLK = 1'b0;
		forever #50 iSCLK = ~iSCLK;
	end

	// ------------------------------
	// Helpers
	// ------------------------------

	task automatic failRun();
		$display("tests failed");
		$fatal(1);
	endtask

	task automatic reportMismatch(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		$display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
		failRun();
	endtask

	// Ends on a falling edge, the drive point
	task automatic waitClocks(input int n);
		repeat (n) @(negedge iSCLK);
	endtask

	function automatic spiWord_t xorshift(input spiWord_t x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic randomWord(output spiWord_t w);
		rngState = xorshift(rngState);
		w = rngState;
	endtask

	// Mode 0 frame, MISO sampled at each SCK rise
	// Partial frame when nBits is below 64
	task automatic sendFrame(input string name, input spiWord_t addr, input spiWord_t data,
		input int nBits);
		logic [63:0] word;
		logic [63:0] captured;
		logic [31:0] expData;
		logic [31:0] gotData;
		logic [31:0] gotIdle;
		int i;
		word = {addr, data};
		captured = '0;
		@(negedge iSCLK);
		iCs = 1'b0;
		iSck = 1'b0;
		iMosi = word[63];
		waitClocks(SCK_HALF);
		for (i = 0; i < nBits; i++)
		begin
			iSck = 1'b1;
			captured = {captured[62:0], oMiso};
			waitClocks(SCK_HALF);
			iSck = 1'b0;
			if (i < 63)
				iMosi = word[62 - i];
			waitClocks(SCK_HALF);
		end
		iCs = 1'b1;
		iMosi = 1'b0;
		waitClocks(CS_GAP);
		// Old register contents, only as many bits as were clocked
		expData = refRegs[addr % REG_COUNT] >> (FRAME_BITS - nBits);
		gotData = 32'(captured & ((64'd1 << (nBits - 32)) - 64'd1));
		assert (gotData === expData) else reportMismatch(name, expData, gotData);
		// Address half reads all ones
		gotIdle = 32'(captured >> (nBits - 32));
		assert (gotIdle === 32'hFFFF_FFFF)
			else reportMismatch({name, " address half"}, 32'hFFFF_FFFF, gotIdle);
	endtask

	// Full frame, then the model follows once the write has landed
	task automatic writeFrame(input string name, input spiWord_t addr, input spiWord_t data);
		sendFrame(name, addr, data, FRAME_BITS);
		waitClocks(GAP_CLKS);
		refRegs[addr % REG_COUNT] = data;
	endtask

	// ------------------------------
	// Protocol checks
	// ------------------------------

	// Overflow is sticky
	assert property (@(posedge iSCLK) disable iff (iSRST) oOverflow |=> oOverflow)
	else
	begin
		$display("Overflow flag cleared without a reset");
		failRun();
	end

	// MISO idles high once CS has settled high
	assert property (@(posedge iSCLK) disable iff (iSRST)
		(iCs && $past(iCs, 1) && $past(iCs, 2) && $past(iCs, 3) && $past(iCs, 4)) |-> oMiso)
	else
	begin
		$display("MISO low while the slave is deselected");
		failRun();
	end

	// Run limit
	always @(posedge iSCLK)
	begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= TIMEOUT_CLKS)
		begin
			$display("Timeout after %0d clocks, the run did not finish", cycleCount);
			failRun();
		end
	end

	// ------------------------------
	// Stimulus
	// ------------------------------

	initial
	begin
		iSRST = 1'b1;
		iSck = 1'b0;
		iCs = 1'b1;
		iMosi = 1'b0;
		iBusGrant = 1'b1;
		cycleCount = 0;
		rngState = 32'h8821_6696;
		for (k = 0; k < REG_COUNT; k++)
			refRegs[k] = '0;
		waitClocks(RESET_CLKS);
		iSRST = 1'b0;
		waitClocks(2);

		// Reset state
		assert (oMiso === 1'b1) else reportMismatch("resetMiso", 32'd1, 32'(oMiso));
		assert (oOverflow === 1'b0) else reportMismatch("resetOverflow", 32'd0, 32'(oOverflow));
		randomWord(addrA);
		randomWord(dataA);
		writeFrame("resetRead", addrA, dataA);

		// Write then read back
		for (k = 0; k < N_RANDOM; k++)
		begin
			randomWord(addrA);
			randomWord(dataA);
			randomWord(dataB);
			writeFrame("writeData", addrA, dataA);
			writeFrame("readBack", addrA, dataB);
		end

		// Aliasing, one REG_COUNT step up
		randomWord(addrA);
		randomWord(dataA);
		randomWord(dataB);
		writeFrame("aliasWrite", addrA, dataA);
		writeFrame("aliasRead", addrA + REG_COUNT, dataB);

		// Stall with grant low, one frame too many
		iBusGrant = 1'b0;
		randomWord(base);
		for (k = 0; k <= FIFO_DEPTH; k++)
		begin
			randomWord(addrA);
			randomWord(dataA);
			stallAddr[k] = (addrA & ~spiWord_t'(REG_COUNT - 1)) |
				spiWord_t'((base + k) % REG_COUNT);
			stallData[k] = dataA;
			sendFrame("stallFrame", stallAddr[k], stallData[k], FRAME_BITS);
		end
		assert (oOverflow === 1'b1) else reportMismatch("overflowFlag", 32'd1, 32'(oOverflow));
		iBusGrant = 1'b1;
		// Backlog drains at about 4 clocks per write
		waitClocks(GAP_CLKS + 8 * FIFO_DEPTH);
		for (k = 0; k < FIFO_DEPTH; k++)
			refRegs[stallAddr[k] % REG_COUNT] = stallData[k];
		// Last frame was dropped, its register keeps the old value
		for (k = 0; k <= FIFO_DEPTH; k++)
		begin
			randomWord(dataB);
			writeFrame("stallRead", stallAddr[k], dataB);
		end

		// CS raised after 40 bits
		randomWord(addrA);
		randomWord(dataA);
		writeFrame("abortSetup", addrA, dataA);
		randomWord(dataB);
		sendFrame("abortFrame", addrA, dataB, 40);
		waitClocks(GAP_CLKS);
		randomWord(dataB);
		writeFrame("abortRead", addrA, dataB);

		$display("all tests passed");
		$finish;
	end

endmodule

// ==== spiBridge.f ====
src/spiPkg.sv
src/busPkg.sv
src/spiSlaveFrontend.sv
src/frameFifo.sv
src/wbRegMaster.sv
src/regBank.sv
src/spiBridgeTop.sv
verification/spiBridgeTb.sv
